//--- Bender.yml
package:
  name: core_exec

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/pipeDefs_pkg.sv
      - logic/regPortIf.sv
      - logic/pipeStageReg.sv
      - logic/instrDecoder.sv
      - logic/regFile.sv
      - logic/execUnit.sv
      - logic/coreExecTop.sv
  - target: test
    include_dirs:
      - logic
    files:
      - verif/coreExecTb.sv

//--- build.f
+incdir+logic
logic/pipeDefs_pkg.sv
logic/regPortIf.sv
logic/pipeStageReg.sv
logic/instrDecoder.sv
logic/regFile.sv
logic/execUnit.sv
logic/coreExecTop.sv
verif/coreExecTb.sv

//--- logic/coreExecTop.sv
`include "pipe_params.svh"

module coreExecTop
    import pipeDefs_pkg::*;
(
    input  logic               clk,
    input  logic               reset,
    input  logic               instrValid,
    input  logic [`DATA_W-1:0] instr,
    input  logic [`DATA_W-1:0] pc,
    input  logic               hold,
    output logic               wbValid,
    output logic [`REG_AW-1:0] wbReg,
    output logic [`DATA_W-1:0] wbData,
    output logic               branchTaken,
    output logic [`DATA_W-1:0] branchTarget
);

    idExBundle_t idExD;
    idExBundle_t idExQ;
    exWbBundle_t exWbD;
    exWbBundle_t exWbQ;

    regReadIf regRead ();
    wbBusIf   wbBus ();

    instrDecoder decoder (
        .instrValid  (instrValid),
        .instr       (instr),
        .pc          (pc),
        .branchTaken (branchTaken),
        .rd          (regRead.reader),
        .bundle      (idExD)
    );

    regFile gprFile (
        .clk   (clk),
        .reset (reset),
        .rd    (regRead.server),
        .wb    (wbBus.sink)
    );

    pipeStageReg #(.payload_t(idExBundle_t)) idExReg (
        .clk   (clk),
        .reset (reset),
        .hold  (hold),
        .d     (idExD),
        .q     (idExQ)
    );

    execUnit execute (
        .clk          (clk),
        .reset        (reset),
        .hold         (hold),
        .bundle       (idExQ),
        .wb           (wbBus.sink),
        .result       (exWbD),
        .branchTaken  (branchTaken),
        .branchTarget (branchTarget)
    );

    pipeStageReg #(.payload_t(exWbBundle_t)) exWbReg (
        .clk   (clk),
        .reset (reset),
        .hold  (hold),
        .d     (exWbD),
        .q     (exWbQ)
    );

    // Writeback bus straight from the EX/WB register
    assign wbBus.valid    = exWbQ.valid;
    assign wbBus.regWrite = exWbQ.regWrite;
    assign wbBus.destReg  = exWbQ.destReg;
    assign wbBus.result   = exWbQ.result;

    // Only register-writing instructions show as a commit
    assign wbValid = wbBus.valid & wbBus.regWrite;
    assign wbReg   = wbBus.destReg;
    assign wbData  = wbBus.result;

endmodule

//--- logic/execUnit.sv
`include "pipe_params.svh"

module execUnit
    import pipeDefs_pkg::*;
(
    input  logic               clk,
    input  logic               reset,
    input  logic               hold,
    input  idExBundle_t        bundle,
    wbBusIf.sink               wb,
    output exWbBundle_t        result,
    output logic               branchTaken,
    output logic [`DATA_W-1:0] branchTarget
);

    logic [`DATA_W-1:0] hi;
    logic [`DATA_W-1:0] lo;
    logic [`DATA_W-1:0] opA;
    logic [`DATA_W-1:0] opB;
    logic [`DATA_W-1:0] aluB;
    logic [`DATA_W-1:0] aluOut;
    logic               fwdOk;
    logic               cond;

    // EX/WB forwarding, register zero never forwards
    assign fwdOk = wb.valid && wb.regWrite && (wb.destReg != '0);
    assign opA = (fwdOk && wb.destReg == bundle.rs) ? wb.result : bundle.srcA;
    assign opB = (fwdOk && wb.destReg == bundle.rt) ? wb.result : bundle.srcB;

    assign aluB = bundle.aluSrcImm ? bundle.signImm : opB;

    always_comb begin
        case (bundle.aluOp)
            ALU_ADD:    aluOut = opA + aluB;
            ALU_SUB:    aluOut = opA - aluB;
            ALU_AND:    aluOut = opA & aluB;
            ALU_OR:     aluOut = opA | aluB;
            ALU_XOR:    aluOut = opA ^ aluB;
            ALU_SLT:    aluOut = {{(`DATA_W-1){1'b0}}, $signed(opA) < $signed(aluB)};
            ALU_LUI:    aluOut = {aluB[15:0], 16'h0000};
            ALU_PASSHI: aluOut = hi;
            ALU_PASSLO: aluOut = lo;
            default:    aluOut = '0;
        endcase
    end

    // HI and LO take the forwarded rs value
    always_ff @(posedge clk) begin
        if (reset) begin
            hi <= '0;
            lo <= '0;
        end else if (bundle.valid && !hold) begin
            if (bundle.hiWrite) begin
                hi <= opA;
            end
            if (bundle.loWrite) begin
                lo <= opA;
            end
        end
    end

    // Branch judgement on forwarded operands
    always_comb begin
        case (bundle.branchKind)
            BR_BEQ:  cond = (opA == opB);
            BR_BNE:  cond = (opA != opB);
            BR_JUMP: cond = 1'b1;
            default: cond = 1'b0;
        endcase
    end

    assign branchTaken = bundle.valid && cond;
    assign branchTarget = bundle.branchTarget;

    always_comb begin
        result.valid = bundle.valid;
        result.regWrite = bundle.regWrite;
        result.destReg = bundle.destReg;
        result.result = aluOut;
    end

endmodule

//--- logic/instrDecoder.sv
`include "pipe_params.svh"

module instrDecoder
    import pipeDefs_pkg::*;
(
    input  logic               instrValid,
    input  logic [`DATA_W-1:0] instr,
    input  logic [`DATA_W-1:0] pc,
    input  logic               branchTaken,
    regReadIf.reader           rd,
    output idExBundle_t        bundle
);

    // Opcodes
    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_J     = 6'h02;
    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] OP_BNE   = 6'h05;
    localparam logic [5:0] OP_ADDIU = 6'h09;
    localparam logic [5:0] OP_SLTI  = 6'h0A;
    localparam logic [5:0] OP_ANDI  = 6'h0C;
    localparam logic [5:0] OP_ORI   = 6'h0D;
    localparam logic [5:0] OP_LUI   = 6'h0F;

    // R-type function codes
    localparam logic [5:0] FN_MFHI = 6'h10;
    localparam logic [5:0] FN_MTHI = 6'h11;
    localparam logic [5:0] FN_MFLO = 6'h12;
    localparam logic [5:0] FN_MTLO = 6'h13;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_SLT  = 6'h2A;

    logic [5:0]         opcode;
    logic [5:0]         funct;
    logic [`REG_AW-1:0] rsField;
    logic [`REG_AW-1:0] rtField;
    logic [`REG_AW-1:0] rdField;
    logic [`DATA_W-1:0] signExt;
    logic [`DATA_W-1:0] zeroExt;
    logic [`DATA_W-1:0] pcPlus4;
    logic               known;

    assign opcode  = instr[31:26];
    assign rsField = instr[25:21];
    assign rtField = instr[20:16];
    assign rdField = instr[15:11];
    assign funct   = instr[5:0];
    assign signExt = {{(`DATA_W-16){instr[15]}}, instr[15:0]};
    assign zeroExt = {{(`DATA_W-16){1'b0}}, instr[15:0]};
    assign pcPlus4 = pc + `DATA_W'd4;

    // Operands are read straight from the instruction fields
    assign rd.addrA = rsField;
    assign rd.addrB = rtField;

    always_comb begin
        known = 1'b1;
        bundle = '0;
        bundle.pc = pc;
        bundle.pcPlus4 = pcPlus4;
        bundle.branchTarget = pcPlus4 + {signExt[`DATA_W-3:0], 2'b00};
        bundle.branchKind = BR_NONE;
        bundle.srcA = rd.dataA;
        bundle.srcB = rd.dataB;
        bundle.signImm = signExt;
        bundle.rs = rsField;
        bundle.rt = rtField;
        bundle.destReg = rtField;
        bundle.aluOp = ALU_NONE;
        case (opcode)
            OP_RTYPE: begin
                bundle.destReg = rdField;
                bundle.regWrite = 1'b1;
                case (funct)
                    FN_ADDU: bundle.aluOp = ALU_ADD;
                    FN_SUBU: bundle.aluOp = ALU_SUB;
                    FN_AND:  bundle.aluOp = ALU_AND;
                    FN_OR:   bundle.aluOp = ALU_OR;
                    FN_XOR:  bundle.aluOp = ALU_XOR;
                    FN_SLT:  bundle.aluOp = ALU_SLT;
                    FN_MFHI: bundle.aluOp = ALU_PASSHI;
                    FN_MFLO: bundle.aluOp = ALU_PASSLO;
                    FN_MTHI: begin
                        bundle.regWrite = 1'b0;
                        bundle.hiWrite = 1'b1;
                    end
                    FN_MTLO: begin
                        bundle.regWrite = 1'b0;
                        bundle.loWrite = 1'b1;
                    end
                    default: known = 1'b0;
                endcase
            end
            OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_LUI: begin
                bundle.aluSrcImm = 1'b1;
                bundle.regWrite = 1'b1;
                case (opcode)
                    OP_ADDIU: bundle.aluOp = ALU_ADD;
                    OP_SLTI:  bundle.aluOp = ALU_SLT;
                    OP_LUI:   bundle.aluOp = ALU_LUI;
                    OP_ANDI: begin
                        bundle.aluOp = ALU_AND;
                        bundle.signImm = zeroExt;
                    end
                    default: begin
                        bundle.aluOp = ALU_OR;
                        bundle.signImm = zeroExt;
                    end
                endcase
            end
            OP_BEQ: bundle.branchKind = BR_BEQ;
            OP_BNE: bundle.branchKind = BR_BNE;
            OP_J: begin
                bundle.branchKind = BR_JUMP;
                bundle.branchTarget = {pcPlus4[`DATA_W-1:28], instr[25:0], 2'b00};
            end
            default: known = 1'b0;
        endcase
        // The younger instruction behind a taken branch is squashed here
        bundle.valid = instrValid && known && !branchTaken;
    end

endmodule

//--- logic/pipeDefs_pkg.sv
`include "pipe_params.svh"

package pipeDefs_pkg;

    // ALU operations selected in decode
    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_AND    = 4'd2,
        ALU_OR     = 4'd3,
        ALU_XOR    = 4'd4,
        ALU_SLT    = 4'd5,
        ALU_LUI    = 4'd6,
        ALU_PASSHI = 4'd7,
        ALU_PASSLO = 4'd8,
        ALU_NONE   = 4'd9
    } aluOp_t;

    // Control flow kind, judged in execute
    typedef enum logic [1:0] {
        BR_NONE = 2'd0,
        BR_BEQ  = 2'd1,
        BR_BNE  = 2'd2,
        BR_JUMP = 2'd3
    } branchKind_t;

    // Decode to execute payload
    typedef struct packed {
        logic               valid;
        logic [`DATA_W-1:0] pc;
        logic [`DATA_W-1:0] pcPlus4;
        logic [`DATA_W-1:0] branchTarget;
        branchKind_t        branchKind;
        logic [`DATA_W-1:0] srcA;
        logic [`DATA_W-1:0] srcB;
        // Already sign or zero extended
        logic [`DATA_W-1:0] signImm;
        logic [`REG_AW-1:0] rs;
        logic [`REG_AW-1:0] rt;
        logic [`REG_AW-1:0] destReg;
        aluOp_t             aluOp;
        logic               aluSrcImm;
        logic               regWrite;
        logic               hiWrite;
        logic               loWrite;
    } idExBundle_t;

    // Execute to writeback payload
    typedef struct packed {
        logic               valid;
        logic               regWrite;
        logic [`REG_AW-1:0] destReg;
        logic [`DATA_W-1:0] result;
    } exWbBundle_t;

endpackage

//--- logic/pipeStageReg.sv
module pipeStageReg #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     hold,
    input  payload_t d,
    output payload_t q
);

    // Reset empties the stage, hold freezes it
    always_ff @(posedge clk) begin
        if (reset) begin
            q <= '0;
        end else if (!hold) begin
            q <= d;
        end
    end

endmodule

//--- logic/pipe_params.svh
`ifndef PIPE_PARAMS_SVH
`define PIPE_PARAMS_SVH

// Datapath and PC width
`define DATA_W 32

// Register address width
`define REG_AW 5

// Architectural general registers
`define REG_COUNT 32

`endif

//--- logic/regFile.sv
`include "pipe_params.svh"

module regFile (
    input  logic     clk,
    input  logic     reset,
    regReadIf.server rd,
    wbBusIf.sink     wb
);

    logic [`DATA_W-1:0] regs [`REG_COUNT];
    logic               wrEn;

    // Register zero is never written
    assign wrEn = wb.valid && wb.regWrite && (wb.destReg != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn) begin
            regs[wb.destReg] <= wb.result;
        end
    end

    // Same-cycle write is visible to the reader
    function automatic logic [`DATA_W-1:0] readPort(input logic [`REG_AW-1:0] addr);
        logic [`DATA_W-1:0] value;
        value = regs[addr];
        if (addr == '0) begin
            value = '0;
        end else if (wrEn && wb.destReg == addr) begin
            value = wb.result;
        end
        return value;
    endfunction

    always_comb begin
        rd.dataA = readPort(rd.addrA);
        rd.dataB = readPort(rd.addrB);
    end

endmodule

//--- logic/regPortIf.sv
`include "pipe_params.svh"

// Two combinational read ports of the register file
interface regReadIf;
    logic [`REG_AW-1:0] addrA;
    logic [`REG_AW-1:0] addrB;
    logic [`DATA_W-1:0] dataA;
    logic [`DATA_W-1:0] dataB;

    modport reader (output addrA, output addrB, input dataA, input dataB);
    modport server (input addrA, input addrB, output dataA, output dataB);
endinterface

// Writeback bus out of the EX/WB register
interface wbBusIf;
    logic               valid;
    logic               regWrite;
    logic [`REG_AW-1:0] destReg;
    logic [`DATA_W-1:0] result;

    modport source (
        output valid,
        output regWrite,
        output destReg,
        output result
    );
    modport sink (
        input valid,
        input regWrite,
        input destReg,
        input result
    );
endinterface

//--- verif/coreExecTb.sv
`include "pipe_params.svh"

module coreExecTb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_HALF     = 4;
    localparam int RESET_CYCLES = 5;
    localparam int MAX_LINES    = 500;
    localparam int NUM_TESTS    = 5;

    logic               clk;
    logic               reset;
    logic               instrValid;
    logic [`DATA_W-1:0] instr;
    logic [`DATA_W-1:0] pc;
    logic               hold;
    logic               wbValid;
    logic [`REG_AW-1:0] wbReg;
    logic [`DATA_W-1:0] wbData;
    logic               branchTaken;
    logic [`DATA_W-1:0] branchTarget;

    int    checks;
    int    errors;
    int    testChecks;
    int    testErrors;
    int    testsRun;
    string testNames [1:NUM_TESTS];

    coreExecTop i_coreExecTop (
        .clk          (clk),
        .reset        (reset),
        .instrValid   (instrValid),
        .instr        (instr),
        .pc           (pc),
        .hold         (hold),
        .wbValid      (wbValid),
        .wbReg        (wbReg),
        .wbData       (wbData),
        .branchTaken  (branchTaken),
        .branchTarget (branchTarget)
    );

    always #CLK_HALF clk = ~clk;

    task automatic checkValue(input string name, input logic [`DATA_W-1:0] got,
                              input logic [`DATA_W-1:0] expected);
        checks++;
        testChecks++;
        assert (got === expected) else begin
            errors++;
            testErrors++;
            $display("** Error at %0t ns: %s is %h, expected %h", $time, name, got, expected);
        end
    endtask

    task automatic reportTest(input int id);
        testsRun++;
        if (testErrors == 0) begin
            $display("test %0d, %s: %0d checks, ok", id, testNames[id], testChecks);
        end else begin
            $display("test %0d, %s: %0d checks, %0d errors", id, testNames[id], testChecks,
                     testErrors);
        end
        testChecks = 0;
        testErrors = 0;
    endtask

    initial begin
        int          fd;
        int          lineNo;
        int          fields;
        int          currentTest;
        string       line;
        logic [31:0] tId;
        logic [31:0] tValid;
        logic [31:0] tInstr;
        logic [31:0] tPc;
        logic [31:0] tHold;
        logic [31:0] eCommit;
        logic [31:0] eReg;
        logic [31:0] eData;
        logic [31:0] eBranch;
        logic [31:0] eTarget;

        testNames[1] = "ALU and immediates";
        testNames[2] = "forwarding";
        testNames[3] = "branches and jumps";
        testNames[4] = "HI and LO";
        testNames[5] = "hold";
        clk = 1'b0;
        reset = 1'b1;
        instrValid = 1'b0;
        instr = '0;
        pc = '0;
        hold = 1'b0;
        checks = 0;
        errors = 0;
        testChecks = 0;
        testErrors = 0;
        testsRun = 0;
        currentTest = 0;

        fd = $fopen("verif/coreExecTrace.txt", "r");

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // Both stages are empty right out of reset
        checkValue("wbValid", wbValid, '0);
        checkValue("branchTaken", branchTaken, '0);
        testChecks = 0;
        testErrors = 0;

        if (fd == 0) begin
            errors++;
            $display("Could not open the trace file verif/coreExecTrace.txt");
        end else begin
            lineNo = 0;
            while (!$feof(fd) && lineNo < MAX_LINES) begin
                line = "";
                fields = $fgets(line, fd);
                lineNo++;
                if (line.len() < 2 || line.getc(0) == "#") begin
                    continue;
                end
                fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h", tId, tValid, tInstr,
                                 tPc, tHold, eCommit, eReg, eData, eBranch, eTarget);
                if (fields != 10) begin
                    errors++;
                    $display("Trace line %0d could not be parsed", lineNo);
                    continue;
                end
                if (tId != currentTest) begin
                    if (currentTest != 0) begin
                        reportTest(currentTest);
                    end
                    currentTest = tId;
                end

                @(negedge clk);
                instrValid = tValid[0];
                instr = tInstr;
                pc = tPc;
                hold = tHold[0];

                // Sample one ns before the rising edge
                #(CLK_HALF - 1);
                if (!hold) begin
                    checkValue("wbValid", wbValid, eCommit);
                    if (eCommit[0]) begin
                        checkValue("wbReg", wbReg, eReg);
                        checkValue("wbData", wbData, eData);
                    end
                    checkValue("branchTaken", branchTaken, eBranch);
                    if (eBranch[0]) begin
                        checkValue("branchTarget", branchTarget, eTarget);
                    end
                end
            end
            $fclose(fd);
        end
        if (currentTest != 0) begin
            reportTest(currentTest);
        end
        if (testsRun != NUM_TESTS) begin
            errors++;
            $display("Trace held %0d tests instead of %0d", testsRun, NUM_TESTS);
        end

        $display("%0d tests, %0d checks, %0d errors", testsRun, checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- verif/coreExecTrace.txt
# test valid instr pc hold, then expected commit reg data and redirect target, all hex
# One line per clock cycle; outputs are checked before the rising edge when hold is 0
1 1 24010005 00000100 0 0 00 00000000 0 00000000
1 1 2402fffd 00000104 0 0 00 00000000 0 00000000
1 1 34038001 00000108 0 1 01 00000005 0 00000000
1 1 3c041234 0000010c 0 1 02 fffffffd 0 00000000
1 1 00222821 00000110 0 1 03 00008001 0 00000000
1 1 00223023 00000114 0 1 04 12340000 0 00000000
1 1 00623824 00000118 0 1 05 00000002 0 00000000
1 1 00814025 0000011c 0 1 06 00000008 0 00000000
1 1 00834826 00000120 0 1 07 00008001 0 00000000
1 1 0041502a 00000124 0 1 08 12340005 0 00000000
1 1 282bffff 00000128 0 1 09 12348001 0 00000000
1 1 304cf0f0 0000012c 0 1 0a 00000001 0 00000000
1 1 24200007 00000130 0 1 0b 00000000 0 00000000
1 1 00016821 00000134 0 1 0c 0000f0f0 0 00000000
1 0 00000000 00000000 0 1 00 0000000c 0 00000000
1 0 00000000 00000000 0 1 0d 00000005 0 00000000
2 1 242e0010 00000138 0 0 00 00000000 0 00000000
2 1 01ce7821 0000013c 0 0 00 00000000 0 00000000
2 1 01ee8023 00000140 0 1 0e 00000015 0 00000000
2 0 00000000 00000000 0 1 0f 0000002a 0 00000000
2 0 00000000 00000000 0 1 10 00000015 0 00000000
3 1 11d00003 00000144 0 0 00 00000000 0 00000000
3 1 24110063 00000148 0 0 00 00000000 1 00000154
3 1 1426002a 00000154 0 0 00 00000000 0 00000000
3 1 24120077 00000158 0 0 00 00000000 1 00000200
3 1 080000c0 00000200 0 0 00 00000000 0 00000000
3 1 24130011 00000204 0 0 00 00000000 1 00000300
3 1 10260005 00000300 0 0 00 00000000 0 00000000
3 1 15d00005 00000304 0 0 00 00000000 0 00000000
3 1 24140042 00000308 0 0 00 00000000 0 00000000
3 0 00000000 00000000 0 0 00 00000000 0 00000000
3 0 00000000 00000000 0 1 14 00000042 0 00000000
4 1 01200011 0000030c 0 0 00 00000000 0 00000000
4 1 24150033 00000310 0 0 00 00000000 0 00000000
4 1 02a00013 00000314 0 0 00 00000000 0 00000000
4 1 0000b010 00000318 0 1 15 00000033 0 00000000
4 1 0000b812 0000031c 0 0 00 00000000 0 00000000
4 0 00000000 00000000 0 1 16 12348001 0 00000000
4 0 00000000 00000000 0 1 17 00000033 0 00000000
5 1 24380100 00000320 0 0 00 00000000 0 00000000
5 1 0301c821 00000324 0 0 00 00000000 0 00000000
5 1 0338d025 00000328 1 0 00 00000000 0 00000000
5 1 0338d025 00000328 1 0 00 00000000 0 00000000
5 1 0338d025 00000328 0 1 18 00000105 0 00000000
5 0 00000000 00000000 0 1 19 0000010a 0 00000000
5 0 00000000 00000000 0 1 1a 0000010f 0 00000000
5 0 00000000 00000000 0 0 00 00000000 0 00000000
